/* ats_shaper.f */
hdl/ats_pkg.sv
hdl/ats_config_table.sv
hdl/ats_bucket_store.sv
hdl/ats_eligibility_calc.sv
hdl/ats_shaper_fsm.sv
hdl/ats_shaper.sv
verif/ats_shaper_checker.sv
verif/ats_shaper_monitor.sv
verif/ats_shaper_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ats_shaper_tb
FILELIST  ?= ats_shaper.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* verif/ats_shaper_tb.sv */
// ---------------------------------------
// ATS shaper testbench
// Applies a table of config writes and
// frames, with random result stalls
// ---------------------------------------

`timescale 1ns/1ns

module ats_shaper_tb;

  import ats_pkg::*;

  localparam int flow_num = 16;
  localparam int no_limit = 1_000_000;

  // One table entry, either a config write or a frame
  typedef struct packed {
    logic     is_cfg;
    cfg_sel_e sel;
    flow_t    flow;
    cv_t      value;
    ts_t      arrival;
    len_t     len;
    ts_t      max_res;
    ts_t      expected;
  } row_t;

  logic       clk;
  logic       rstn;
  logic       req_valid;
  logic       req_ready;
  logic       res_valid;
  logic       res_ready;
  logic       exp_push;
  frame_req_t req;
  cfg_wr_t    cfg;
  ts_t        max_residence;
  ts_t        res_time;
  ts_t        exp_value;
  int         mon_errors;
  int         res_count;
  int         tb_errors;
  int         n_frames;
  bit         aborted;
  bit         ok;
  integer     seed = 32'ha1f7237a;
  row_t       rows[$];

  ats_shaper #(
    .flow_num (flow_num)
  ) u_dut (
    .clk           (clk),
    .rstn          (rstn),
    .req           (req),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .cfg           (cfg),
    .max_residence (max_residence),
    .res_time      (res_time),
    .res_valid     (res_valid),
    .res_ready     (res_ready)
  );

  ats_shaper_monitor u_mon (
    .clk       (clk),
    .rstn      (rstn),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_time  (res_time),
    .exp_push  (exp_push),
    .exp_value (exp_value),
    .err_count (mon_errors),
    .res_count (res_count)
  );

  // Handshake checker on the DUT ports
  bind ats_shaper ats_shaper_checker u_chk (
    .clk       (clk),
    .rstn      (rstn),
    .req_ready (req_ready),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_time  (res_time)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Random back-pressure, about one cycle in four
  initial begin
    res_ready = 1'b0;
    forever begin
      @(negedge clk);
      res_ready = rstn && (($random(seed) & 3) != 0);
    end
  end

  function automatic row_t cfg_row(input int flow, input cfg_sel_e sel, input int value);
    row_t r;
    r        = '0;
    r.is_cfg = 1'b1;
    r.flow   = flow_t'(flow);
    r.sel    = sel;
    r.value  = cv_t'(value);
    return r;
  endfunction

  function automatic row_t frame_row(input int flow, input int arrival, input int len,
                                     input int max_res, input int expected);
    row_t r;
    r          = '0;
    r.flow     = flow_t'(flow);
    r.arrival  = ts_t'(arrival);
    r.len      = len_t'(len);
    r.max_res  = ts_t'(max_res);
    r.expected = ts_t'(expected);
    return r;
  endfunction

  task automatic wait_req_ready(input int limit, input string what, output bit ready_seen);
    int n;
    n = 0;
    @(negedge clk);
    while (!req_ready && n < limit) begin
      @(negedge clk);
      n++;
    end
    ready_seen = req_ready;
    if (!ready_seen) begin
      $display("Timeout: req_ready stayed low %s", what);
    end
  endtask

  task automatic wait_results(input int limit, output bit all_seen);
    int n;
    n = 0;
    while (res_count < n_frames && n < limit) begin
      @(negedge clk);
      n++;
    end
    all_seen = (res_count >= n_frames);
    if (!all_seen) begin
      $display("Timeout: only %0d of %0d results arrived", res_count, n_frames);
    end
  endtask

  // Called on a falling edge with the DUT idle
  task automatic apply_row(input row_t r);
    if (r.is_cfg) begin
      cfg = '{wr: 1'b1, flow: r.flow, sel: r.sel, value: r.value};
    end else begin
      req           = '{flow: r.flow, arrival: r.arrival, len: r.len};
      req_valid     = 1'b1;
      max_residence = r.max_res;
      exp_value     = r.expected;
      exp_push      = 1'b1;
    end
    @(negedge clk);
    cfg.wr    = 1'b0;
    req_valid = 1'b0;
    exp_push  = 1'b0;
  endtask

  // ---------------------------------------
  // Stimulus table
  // ---------------------------------------
  task automatic build_table();
    // Unconfigured flows follow arrival and group time
    rows.push_back(frame_row(0, 1000, 100, no_limit, 1000));
    rows.push_back(frame_row(1, 500, 100, no_limit, 1000));
    // Flow 2 at 8 ps per byte, 300 byte burst
    rows.push_back(cfg_row(2, cfg_rate_inv, 8));
    rows.push_back(cfg_row(2, cfg_burst, 300));
    rows.push_back(frame_row(2, 2000, 100, no_limit, 2000));
    rows.push_back(frame_row(2, 2000, 100, no_limit, 2000));
    rows.push_back(frame_row(2, 2000, 100, no_limit, 2400));
    rows.push_back(frame_row(2, 2000, 100, no_limit, 3200));
    rows.push_back(frame_row(2, 2000, 100, no_limit, 4000));
    // Flow 3 has its own bucket, group time still applies
    rows.push_back(cfg_row(3, cfg_rate_inv, 4));
    rows.push_back(cfg_row(3, cfg_burst, 200));
    rows.push_back(frame_row(3, 2100, 50, no_limit, 4000));
    rows.push_back(frame_row(2, 2100, 100, no_limit, 4800));
    rows.push_back(frame_row(3, 2200, 50, no_limit, 4800));
    // Discard, then group time and flow 2 bucket both still untouched
    rows.push_back(frame_row(2, 2200, 100, 1000, 0));
    rows.push_back(frame_row(0, 2200, 10, no_limit, 4800));
    rows.push_back(frame_row(2, 2200, 100, no_limit, 5600));
    rows.push_back(frame_row(0, 6000, 10, no_limit, 6000));
    rows.push_back(frame_row(1, 7000, 10, no_limit, 7000));
    n_frames = 0;
    foreach (rows[i]) begin
      if (!rows[i].is_cfg) begin
        n_frames++;
      end
    end
  endtask

  // ---------------------------------------
  // Main sequence
  // ---------------------------------------
  initial begin
    rstn          = 1'b0;
    req           = '0;
    req_valid     = 1'b0;
    cfg           = '0;
    max_residence = '0;
    exp_push      = 1'b0;
    exp_value     = '0;
    tb_errors     = 0;
    aborted       = 1'b0;
    build_table();
    repeat (10) @(negedge clk);
    rstn = 1'b1;
    if (res_valid !== 1'b0) begin
      $display("res_valid is not low right after reset");
      tb_errors++;
    end
    wait_req_ready(flow_num + 8, "after the clearing sweep", ok);
    aborted = !ok;
    for (int i = 0; i < rows.size() && !aborted; i++) begin
      wait_req_ready(200, "before the next table row", ok);
      if (ok) begin
        apply_row(rows[i]);
      end else begin
        aborted = 1'b1;
      end
    end
    if (!aborted) begin
      wait_results(200, ok);
      aborted = !ok;
    end
    if (aborted) begin
      tb_errors++;
    end
    $display("Results %0d of %0d, monitor errors %0d, testbench errors %0d",
             res_count, n_frames, mon_errors, tb_errors);
    if (mon_errors == 0 && tb_errors == 0 && res_count == n_frames) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* verif/ats_shaper_monitor.sv */
// ---------------------------------------
// ATS result monitor
// Compares each accepted result with the
// next expected value in order
// ---------------------------------------

`timescale 1ns/1ns

module ats_shaper_monitor (
  input  logic         clk,
  input  logic         rstn,
  input  logic         res_valid,
  input  logic         res_ready,
  input  ats_pkg::ts_t res_time,
  input  logic         exp_push,
  input  ats_pkg::ts_t exp_value,
  output int           err_count,
  output int           res_count
);

  import ats_pkg::*;

  ts_t exp_q[$];
  ts_t exp_now;

  initial begin
    err_count = 0;
    res_count = 0;
  end

  always @(posedge clk) begin
    if (rstn && res_valid && res_ready) begin
      if (exp_q.size() == 0) begin
        $display("Result 0x%h arrived with no frame pending", res_time);
        err_count++;
      end else begin
        exp_now = exp_q.pop_front();
        if (res_time !== exp_now) begin
          $display("Mismatch res_time: got 0x%h, expected 0x%h (result %0d)",
                   res_time, exp_now, res_count);
          err_count++;
        end
        res_count++;
      end
    end
    // New frames are queued after any result on the same edge
    if (exp_push) begin
      exp_q.push_back(exp_value);
    end
  end

endmodule

/* verif/ats_shaper_checker.sv */
// ---------------------------------------
// ATS handshake checker
// Result hold, ready exclusion and reset
// ---------------------------------------

`timescale 1ns/1ns

module ats_shaper_checker (
  input logic         clk,
  input logic         rstn,
  input logic         req_ready,
  input logic         res_valid,
  input logic         res_ready,
  input ats_pkg::ts_t res_time
);

  // Stalled result keeps its value
  a_res_hold: assert property (@(posedge clk) disable iff (!rstn)
    (res_valid && !res_ready) |=> (res_valid && $stable(res_time)))
    else $error("res_time or res_valid changed while the result was stalled");

  a_ready_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(req_ready && res_valid))
    else $error("req_ready and res_valid were high together");

  a_reset_quiet: assert property (@(posedge clk)
    !rstn |=> (!req_ready && !res_valid))
    else $error("handshake outputs not low after a reset cycle");

endmodule

/* hdl/ats_shaper.sv */
// ---------------------------------------
// ATS shaper top level
// Per-flow token-bucket eligibility time
// ---------------------------------------

`timescale 1ns/1ns

module ats_shaper #(
  parameter int flow_num = 16
) (
  input  logic                clk,
  input  logic                rstn,
  input  ats_pkg::frame_req_t req,
  input  logic                req_valid,
  output logic                req_ready,
  input  ats_pkg::cfg_wr_t    cfg,
  input  ats_pkg::ts_t        max_residence,
  output ats_pkg::ts_t        res_time,
  output logic                res_valid,
  input  logic                res_ready
);

  import ats_pkg::*;

  frame_req_t req_hold;
  calc_step_e step;
  cv_t        rate_inv;
  cv_t        burst;
  ts_t        bucket_empty;
  ts_t        new_empty;
  logic       wen;
  logic       clear_done;

  ats_shaper_fsm u_fsm (
    .clk        (clk),
    .rstn       (rstn),
    .req_valid  (req_valid),
    .req        (req),
    .clear_done (clear_done),
    .res_ready  (res_ready),
    .req_ready  (req_ready),
    .res_valid  (res_valid),
    .req_hold   (req_hold),
    .step       (step)
  );

  ats_config_table #(
    .flow_num (flow_num)
  ) u_table (
    .clk      (clk),
    .rstn     (rstn),
    .cfg      (cfg),
    .flow     (req_hold.flow),
    .step     (step),
    .rate_inv (rate_inv),
    .burst    (burst)
  );

  ats_bucket_store #(
    .flow_num (flow_num)
  ) u_store (
    .clk          (clk),
    .rstn         (rstn),
    .flow         (req_hold.flow),
    .step         (step),
    .wen          (wen),
    .new_empty    (new_empty),
    .bucket_empty (bucket_empty),
    .clear_done   (clear_done)
  );

  ats_eligibility_calc u_calc (
    .clk           (clk),
    .rstn          (rstn),
    .step          (step),
    .req           (req_hold),
    .rate_inv      (rate_inv),
    .burst         (burst),
    .bucket_empty  (bucket_empty),
    .max_residence (max_residence),
    .wen           (wen),
    .new_empty     (new_empty),
    .res_time      (res_time)
  );

endmodule

/* hdl/ats_shaper_fsm.sv */
// ---------------------------------------
// ATS sequencer
// Takes one request, steps the datapath,
// holds the result until it is taken
// ---------------------------------------

`timescale 1ns/1ns

module ats_shaper_fsm (
  input  logic                clk,
  input  logic                rstn,
  input  logic                req_valid,
  input  ats_pkg::frame_req_t req,
  input  logic                clear_done,
  input  logic                res_ready,
  output logic                req_ready,
  output logic                res_valid,
  output ats_pkg::frame_req_t req_hold,
  output ats_pkg::calc_step_e step
);

  import ats_pkg::*;

  calc_step_e state;
  calc_step_e state_next;

  assign req_ready = (state == st_idle);
  assign res_valid = (state == st_output);
  assign step      = state;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= st_clear;
    end else begin
      state <= state_next;
    end
  end

  // Request stays put for the whole calculation
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      req_hold <= req;
    end
  end

  // ---------------------------------------
  // Next state
  // ---------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      st_clear: begin
        if (clear_done) begin
          state_next = st_idle;
        end
      end
      st_idle: begin
        if (req_valid) begin
          state_next = st_fetch;
        end
      end
      st_fetch:  state_next = st_mult;
      st_mult:   state_next = st_sum;
      st_sum:    state_next = st_pick;
      st_pick:   state_next = st_prep;
      st_prep:   state_next = st_commit;
      st_commit: state_next = st_output;
      // Back-pressure keeps us here
      st_output: begin
        if (res_ready) begin
          state_next = st_idle;
        end
      end
      default: state_next = st_clear;
    endcase
  end

endmodule

/* hdl/ats_eligibility_calc.sv */
// ---------------------------------------
// ATS eligibility datapath
// One register stage per step, plus the
// shared group time and discard decision
// ---------------------------------------

`timescale 1ns/1ns

module ats_eligibility_calc (
  input  logic                clk,
  input  logic                rstn,
  input  ats_pkg::calc_step_e step,
  input  ats_pkg::frame_req_t req,
  input  ats_pkg::cv_t        rate_inv,
  input  ats_pkg::cv_t        burst,
  input  ats_pkg::ts_t        bucket_empty,
  input  ats_pkg::ts_t        max_residence,
  output logic                wen,
  output ats_pkg::ts_t        new_empty,
  output ats_pkg::ts_t        res_time
);

  import ats_pkg::*;

  logic [len_width+cv_width-1:0] len_prod;
  logic [2*cv_width-1:0]         burst_prod;
  ts_t  len_rec;
  ts_t  empty_to_full;
  ts_t  sched;
  ts_t  full_time;
  ts_t  elig;
  ts_t  elig_next;
  ts_t  limit;
  ts_t  over_sum;
  ts_t  group_time;
  logic accept;

  // Unsigned products of the rate with length and burst
  assign len_prod   = {{cv_width{1'b0}}, req.len} * {{len_width{1'b0}}, rate_inv};
  assign burst_prod = {{cv_width{1'b0}}, burst} * {{cv_width{1'b0}}, rate_inv};

  // Latest of arrival, group and scheduler time
  always_comb begin
    elig_next = req.arrival;
    if (group_time > elig_next) begin
      elig_next = group_time;
    end
    if (sched > elig_next) begin
      elig_next = sched;
    end
  end

  // ---------------------------------------
  // Step registers
  // ---------------------------------------
  always_ff @(posedge clk) begin
    case (step)
      st_mult: begin
        len_rec       <= ts_t'(len_prod);
        empty_to_full <= ts_t'(burst_prod);
      end
      st_sum: begin
        sched     <= sat_add(bucket_empty, len_rec);
        full_time <= sat_add(bucket_empty, empty_to_full);
      end
      st_pick: elig <= elig_next;
      st_prep: begin
        limit    <= sat_add(req.arrival, max_residence);
        over_sum <= sat_add(sched, elig);
      end
      // Zero tells the switch to drop the frame
      st_commit: res_time <= accept ? elig : '0;
      default: ;
    endcase
  end

  // ---------------------------------------
  // Commit
  // ---------------------------------------
  assign accept    = (elig <= limit);
  assign wen       = (step == st_commit) && accept;
  // Bucket overfilled, carry only the excess past full
  assign new_empty = (elig < full_time) ? sched :
                     (over_sum > full_time) ? over_sum - full_time : '0;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      group_time <= '0;
    end else if (wen) begin
      group_time <= elig;
    end
  end

endmodule

/* hdl/ats_bucket_store.sv */
// ---------------------------------------
// ATS bucket store
// Bucket-empty time per flow, swept to
// zero one entry per cycle after reset
// ---------------------------------------

`timescale 1ns/1ns

module ats_bucket_store #(
  parameter int flow_num = 16
) (
  input  logic                clk,
  input  logic                rstn,
  input  ats_pkg::flow_t      flow,
  input  ats_pkg::calc_step_e step,
  input  logic                wen,
  input  ats_pkg::ts_t        new_empty,
  output ats_pkg::ts_t        bucket_empty,
  output logic                clear_done
);

  import ats_pkg::*;

  localparam int idx_width = $clog2(flow_num);

  ts_t                  mem [flow_num];
  logic [idx_width-1:0] clr_idx;

  // Sweep counter, done after the last entry
  always_ff @(posedge clk) begin
    if (!rstn) begin
      clr_idx    <= '0;
      clear_done <= 1'b0;
    end else if (!clear_done) begin
      clr_idx <= clr_idx + idx_width'(1);
      if (clr_idx == idx_width'(flow_num - 1)) begin
        clear_done <= 1'b1;
      end
    end
  end

  // Sweep owns the write port until it finishes
  always_ff @(posedge clk) begin
    if (!clear_done) begin
      mem[clr_idx] <= '0;
    end else if (wen && step == st_commit) begin
      mem[flow] <= new_empty;
    end
    if (step == st_fetch) begin
      bucket_empty <= mem[flow];
    end
  end

endmodule

/* hdl/ats_config_table.sv */
// ---------------------------------------
// ATS per-flow configuration table
// Committed rate (ps per byte) and burst
// ---------------------------------------

`timescale 1ns/1ns

module ats_config_table #(
  parameter int flow_num = 16
) (
  input  logic                clk,
  input  logic                rstn,
  input  ats_pkg::cfg_wr_t    cfg,
  input  ats_pkg::flow_t      flow,
  input  ats_pkg::calc_step_e step,
  output ats_pkg::cv_t        rate_inv,
  output ats_pkg::cv_t        burst
);

  import ats_pkg::*;

  cv_t rate_tab  [flow_num];
  cv_t burst_tab [flow_num];

  // ---------------------------------------
  // Write side
  // ---------------------------------------

  // Unconfigured flows read back as zero
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < flow_num; i++) begin
        rate_tab[i]  <= '0;
        burst_tab[i] <= '0;
      end
    end else if (cfg.wr) begin
      if (cfg.sel == cfg_rate_inv) begin
        rate_tab[cfg.flow] <= cfg.value;
      end else begin
        burst_tab[cfg.flow] <= cfg.value;
      end
    end
  end

  // ---------------------------------------
  // Read side
  // ---------------------------------------

  // Both values land at the start of mult
  always_ff @(posedge clk) begin
    if (step == st_fetch) begin
      rate_inv <= rate_tab[flow];
      burst    <= burst_tab[flow];
    end
  end

endmodule

/* hdl/ats_pkg.sv */
// ---------------------------------------
// ATS shared definitions
// Widths, request and config structs, the
// sequencer step enum and saturating add
// ---------------------------------------

package ats_pkg;

  localparam int ts_width   = 72;
  localparam int flow_width = 4;
  localparam int len_width  = 16;
  localparam int cv_width   = 32;

  typedef logic [ts_width-1:0]   ts_t;
  typedef logic [flow_width-1:0] flow_t;
  typedef logic [len_width-1:0]  len_t;
  typedef logic [cv_width-1:0]   cv_t;

  // One frame as handed to the shaper
  typedef struct packed {
    flow_t flow;
    ts_t   arrival;
    len_t  len;
  } frame_req_t;

  typedef enum logic {
    cfg_rate_inv,
    cfg_burst
  } cfg_sel_e;

  // Single-cycle write into the per-flow table
  typedef struct packed {
    logic     wr;
    flow_t    flow;
    cfg_sel_e sel;
    cv_t      value;
  } cfg_wr_t;

  typedef enum logic [3:0] {
    st_clear,
    st_idle,
    st_fetch,
    st_mult,
    st_sum,
    st_pick,
    st_prep,
    st_commit,
    st_output
  } calc_step_e;

  // Add two timestamps, pinning to all ones on overflow
  function automatic ts_t sat_add(input ts_t a, input ts_t b);
    logic [ts_width:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return sum[ts_width] ? '1 : sum[ts_width-1:0];
  endfunction

endpackage
